/* compile.f */
source/decode_pkg.sv
source/inst_decoder.sv
source/dispatch_control.sv
source/dispatch_buffer.sv
source/decode_dispatch.sv
sim/decode_dispatch_tb.sv

/* sim/decode_dispatch_tb.sv */
`timescale 1ns/100ps
// directed testbench for the decode and dispatch stage
// a reference decoder restates the decode table, and a queue model tracks occupancy
// inputs change on the falling edge and outputs are sampled 1 ns later
module decode_dispatch_tb import decode_pkg::*; ();

  localparam logic [31:0] lfsr_seed = 32'hbd07_2f8f;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003; // x^32+x^22+x^2+x+1
  localparam int timeout_cycles = 50;
  localparam int reset_cycles   = 16;
  localparam int stream_tags    = 24;

  typedef struct packed {
    opa_sel_e                 opa;
    opb_sel_e                 opb;
    alu_func_e                alu;
    logic [reg_idx_width-1:0] dest;
    logic [5:0]               flags; // halt, illegal, rd, wr, cond, uncond
  } dec_t;

  logic clock, reset, fetch_valid0, fetch_valid1;
  logic [inst_width-1:0] fetch_inst0, fetch_inst1;
  logic [cap_width-1:0] rob_cap, rs_cap, lsq_cap, fetch_need;
  logic disp_valid0, disp_valid1;
  opa_sel_e disp_opa_select0, disp_opa_select1;
  opb_sel_e disp_opb_select0, disp_opb_select1;
  alu_func_e disp_alu_func0, disp_alu_func1;
  logic [reg_idx_width-1:0] disp_ra_idx0, disp_ra_idx1, disp_rb_idx0, disp_rb_idx1;
  logic [reg_idx_width-1:0] disp_dest_idx0, disp_dest_idx1;
  logic disp_rd_mem0, disp_rd_mem1, disp_wr_mem0, disp_wr_mem1;
  logic disp_cond_branch0, disp_cond_branch1, disp_uncond_branch0, disp_uncond_branch1;
  logic disp_halt0, disp_halt1, disp_illegal0, disp_illegal1;
  logic [31:0] lfsr = lfsr_seed;
  int checks = 0;
  int errors = 0;

  decode_dispatch dut (.*);

  always #5 clock = ~clock; // 10 ns period

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr[0]}; // one step per bit
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? lfsr_taps : 32'h0);
    end
    return v;
  endfunction

  function automatic logic [cap_width-1:0] rand_cap();
    logic [31:0] r;
    r = rand_bits(2);
    return (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
  endfunction

  // integer groups as {opcode, function code, alu op}
  function automatic logic [17:0] int_entry(input int k);
    case (k)
      0:  return {op_inta, fn_addq, alu_addq};
      1:  return {op_inta, fn_subq, alu_subq};
      2:  return {op_inta, fn_cmpult, alu_cmpult};
      3:  return {op_inta, fn_cmpeq, alu_cmpeq};
      4:  return {op_inta, fn_cmpule, alu_cmpule};
      5:  return {op_inta, fn_cmplt, alu_cmplt};
      6:  return {op_inta, fn_cmple, alu_cmple};
      7:  return {op_intl, fn_and, alu_and};
      8:  return {op_intl, fn_bic, alu_bic};
      9:  return {op_intl, fn_bis, alu_bis};
      10: return {op_intl, fn_ornot, alu_ornot};
      11: return {op_intl, fn_xor, alu_xor};
      12: return {op_intl, fn_eqv, alu_eqv};
      13: return {op_ints, fn_srl, alu_srl};
      14: return {op_ints, fn_sll, alu_sll};
      15: return {op_ints, fn_sra, alu_sra};
      default: return {op_intm, fn_mulq, alu_mulq};
    endcase
  endfunction

  function automatic dec_t ref_decode(input logic [31:0] inst);
    dec_t d;
    logic [17:0] e;
    d = '{opa_is_rega, opb_is_regb, alu_addq, zero_reg, 6'b0}; // noop fields
    case (inst[31:26])
      op_pal: d.flags = (inst[25:0] == '0) ? 6'b100000 : 6'b010000;
      op_inta, op_intl, op_ints, op_intm:
      begin
        d.flags = 6'b010000; // until a function code matches
        for (int k = 0; k < 17; k++)
        begin
          e = int_entry(k);
          if (e[17:12] == inst[31:26] && e[11:5] == inst[11:5])
            d = '{opa_is_rega, inst[12] ? opb_is_alu_imm : opb_is_regb,
                  alu_func_e'(e[4:0]), inst[4:0], 6'b0};
        end
      end
      op_jsr: d = '{opa_is_not3, opb_is_regb, alu_and, inst[25:21], 6'b000001};
      op_lda: d = '{opa_is_mem_disp, opb_is_regb, alu_addq, inst[25:21], 6'b0};
      op_ldq: d = '{opa_is_mem_disp, opb_is_regb, alu_addq, inst[25:21], 6'b001000};
      op_stq: d.flags = 6'b000100;
      op_br, op_bsr: d = '{opa_is_npc, opb_is_br_disp, alu_addq, inst[25:21], 6'b000001};
      default:
        if (inst[31:29] == 3'b111)
          d = '{opa_is_rega, opb_is_br_disp, alu_addq, zero_reg, 6'b000010}; // cond branch
        else
          d.flags = 6'b010000;
    endcase
    return d;
  endfunction

  function automatic logic [31:0] make_int(input logic [5:0] op, input logic [6:0] fn,
                                           input logic lit);
    logic [31:0] r;
    r = rand_bits(18);
    return {op, r[17:13], r[12:5], lit, fn, r[4:0]}; // ra, rb or literal, rc
  endfunction

  function automatic logic [31:0] make_word(input logic [5:0] op);
    logic [31:0] r;
    r = rand_bits(26);
    return {op, r[25:0]};
  endfunction

  function automatic logic [31:0] make_tagged(input int tag);
    return {op_inta, 5'd1, 5'd2, 3'b0, 1'b0, fn_addq, 5'(tag)}; // rc carries the tag
  endfunction

  function automatic logic [cap_width-1:0] valid_lanes();
    return cap_width'(disp_valid0) + cap_width'(disp_valid1);
  endfunction

  task automatic report(input string what, input string got, input string exp);
    errors++;
    $display("ERROR at %0t: %s got %s expected %s", $time, what, got, exp);
  endtask

  task automatic check_alu_func(input string what, input alu_func_e got, input alu_func_e exp);
    checks++;
    if (got !== exp)
      report({what, " alu_func"}, got.name(), exp.name());
  endtask

  task automatic check_selects(input string what, input opa_sel_e got_a, input opb_sel_e got_b,
                               input opa_sel_e exp_a, input opb_sel_e exp_b);
    checks++;
    if (got_a !== exp_a || got_b !== exp_b)
      report({what, " selects"}, {got_a.name(), "/", got_b.name()},
             {exp_a.name(), "/", exp_b.name()});
  endtask

  task automatic check_reg_idx(input string what, input logic [reg_idx_width-1:0] got,
                               input logic [reg_idx_width-1:0] exp);
    checks++;
    if (got !== exp)
      report(what, $sformatf("r%0d", got), $sformatf("r%0d", exp));
  endtask

  task automatic check_flags(input string what, input logic [5:0] got, input logic [5:0] exp);
    checks++;
    if (got !== exp)
      report({what, " flags"}, $sformatf("%b", got), $sformatf("%b", exp));
  endtask

  task automatic check_count(input string what, input logic [cap_width-1:0] got,
                             input logic [cap_width-1:0] exp);
    checks++;
    if (got !== exp)
      report(what, $sformatf("%0d", got), $sformatf("%0d", exp));
  endtask

  task automatic drive_fetch(input int n, input logic [31:0] a, input logic [31:0] b);
    fetch_inst0  = a;
    fetch_inst1  = b;
    fetch_valid0 = (n > 0);
    fetch_valid1 = (n > 1); // lane 1 only with lane 0
  endtask

  task automatic wait_for_need(input logic [cap_width-1:0] need, output bit ok);
    ok = 1'b0;
    for (int t = 0; t < timeout_cycles && !ok; t++)
    begin
      @(negedge clock);
      #1 ok = (fetch_need == need);
    end
    if (!ok)
    begin
      errors++;
      $display("fetch_need did not reach %0d within %0d cycles", need, timeout_cycles);
    end
  endtask

  task automatic check_lane(input int lane, input logic [31:0] inst);
    dec_t  exp;
    string tag;
    exp = ref_decode(inst);
    tag = $sformatf("lane%0d inst %h", lane, inst);
    if (lane == 0)
    begin
      check_selects(tag, disp_opa_select0, disp_opb_select0, exp.opa, exp.opb);
      check_alu_func(tag, disp_alu_func0, exp.alu);
      check_reg_idx({tag, " ra"}, disp_ra_idx0, inst[25:21]);
      check_reg_idx({tag, " rb"}, disp_rb_idx0, inst[20:16]);
      check_reg_idx({tag, " dest"}, disp_dest_idx0, exp.dest);
      check_flags(tag, {disp_halt0, disp_illegal0, disp_rd_mem0, disp_wr_mem0,
                        disp_cond_branch0, disp_uncond_branch0}, exp.flags);
    end
    else
    begin
      check_selects(tag, disp_opa_select1, disp_opb_select1, exp.opa, exp.opb);
      check_alu_func(tag, disp_alu_func1, exp.alu);
      check_reg_idx({tag, " ra"}, disp_ra_idx1, inst[25:21]);
      check_reg_idx({tag, " rb"}, disp_rb_idx1, inst[20:16]);
      check_reg_idx({tag, " dest"}, disp_dest_idx1, exp.dest);
      check_flags(tag, {disp_halt1, disp_illegal1, disp_rd_mem1, disp_wr_mem1,
                        disp_cond_branch1, disp_uncond_branch1}, exp.flags);
    end
  endtask

  // pair goes in on one edge and both lanes should dispatch the cycle after
  task automatic decode_pair(input logic [31:0] a, input logic [31:0] b);
    bit ok;
    wait_for_need(2'd2, ok);
    if (!ok)
      return;
    @(negedge clock);
    drive_fetch(2, a, b);
    @(negedge clock);
    drive_fetch(0, noop_inst, noop_inst);
    #1;
    check_count("dispatched lanes", valid_lanes(), 2'd2);
    check_lane(0, a); // older word stays on lane 0
    check_lane(1, b);
  endtask

  task automatic end_test(input string name, input int start);
    $display("test %s: %0d errors", name, errors - start);
  endtask

  task automatic reset_test();
    int start;
    start = errors;
    @(negedge clock);
    #1;
    check_count("lanes after reset", valid_lanes(), 2'd0);
    check_count("fetch_need after reset", fetch_need, 2'd2);
    end_test("reset state", start);
  endtask

  task automatic integer_decode_test();
    int start;
    logic [17:0] e;
    start = errors;
    for (int k = 0; k < 17; k++)
    begin
      e = int_entry(k);
      decode_pair(make_int(e[17:12], e[11:5], 1'b0), make_int(e[17:12], e[11:5], 1'b1));
    end
    end_test("integer decode", start);
  endtask

  task automatic mem_branch_test();
    int start;
    start = errors;
    decode_pair(make_word(op_lda), make_word(op_ldq));
    decode_pair(make_word(op_stq), make_word(op_jsr));
    decode_pair(make_word(op_br), make_word(op_bsr));
    for (int k = 0; k < 4; k++)
      decode_pair(make_word(6'(6'h38 + 2 * k)), make_word(6'(6'h39 + 2 * k)));
    end_test("memory jump branch decode", start);
  endtask

  task automatic halt_illegal_test();
    int start;
    start = errors;
    decode_pair({op_pal, 26'h0}, make_word(op_pal) | 32'h1); // halt, then other pal
    decode_pair(make_word(6'h31), make_word(6'h32)); // fp branches
    decode_pair(make_word(6'h33), make_word(6'h35));
    decode_pair(make_word(6'h36), make_word(6'h37));
    decode_pair(make_int(op_inta, 7'h7f, 1'b0), make_int(op_intl, 7'h01, 1'b1));
    decode_pair(make_int(op_ints, 7'h00, 1'b0), make_int(op_intm, 7'h21, 1'b1));
    decode_pair(make_word(6'h05), make_word(6'h3a)); // legal branch behind an illegal
    end_test("halt and illegal", start);
  endtask

  task automatic backpressure_test();
    int start;
    start = errors;
    @(negedge clock);
    rs_cap = 2'd0;
    drive_fetch(2, make_tagged(3), make_tagged(4));
    #1;
    check_count("stalled fetch_need n=0", fetch_need, 2'd2);
    check_count("stalled lanes", valid_lanes(), 2'd0);
    for (int c = 0; c < 2; c++)
    begin
      @(negedge clock);
      drive_fetch(2, make_tagged(5), make_tagged(6)); // refused while full
      #1;
      check_count("stalled fetch_need n=2", fetch_need, 2'd0);
      check_count("stalled lanes", valid_lanes(), 2'd0);
    end
    @(negedge clock);
    drive_fetch(0, noop_inst, noop_inst);
    rs_cap = 2'd2;
    #1;
    check_count("released lanes", valid_lanes(), 2'd2);
    check_count("released fetch_need", fetch_need, 2'd2);
    check_reg_idx("released lane0 tag", disp_dest_idx0, 5'd3);
    check_reg_idx("released lane1 tag", disp_dest_idx1, 5'd4);
    @(negedge clock);
    #1;
    check_count("lanes after drain", valid_lanes(), 2'd0);
    end_test("back-pressure", start);
  endtask

  task automatic partial_dispatch_test();
    int start, sent, done, offer, n, c, exp_cnt, exp_need;
    int model_q[$]; // tags held in the buffer, oldest first
    start = errors;
    sent  = 0;
    done  = 0;
    for (int cycle = 0; cycle < 400 && done < stream_tags; cycle++)
    begin
      @(negedge clock);
      rob_cap = rand_cap();
      rs_cap  = rand_cap();
      lsq_cap = rand_cap();
      offer   = (sent < stream_tags) ? int'(rand_cap()) : 0;
      if (offer > stream_tags - sent)
        offer = stream_tags - sent;
      drive_fetch(offer, make_tagged(sent), make_tagged(sent + 1));
      #1;
      n        = model_q.size();
      c        = (rob_cap < rs_cap) ? rob_cap : rs_cap;
      c        = (lsq_cap < c) ? lsq_cap : c;
      exp_cnt  = (n < c) ? n : c;
      exp_need = 2 - n + exp_cnt;
      check_count("stream fetch_need", fetch_need, 2'(exp_need));
      check_count("stream lanes", valid_lanes(), 2'(exp_cnt));
      for (int k = 0; k < exp_cnt; k++)
        check_reg_idx($sformatf("stream lane%0d tag", k), k ? disp_dest_idx1 : disp_dest_idx0,
                      5'(model_q.pop_front()));
      done += exp_cnt;
      for (int k = 0; k < ((offer < exp_need) ? offer : exp_need); k++)
      begin
        model_q.push_back(sent); // accepted lanes join in order
        sent++;
      end
    end
    if (done < stream_tags)
    begin
      errors++;
      $display("stream stalled, only %0d of %0d tags dispatched", done, stream_tags);
    end
    @(negedge clock);
    drive_fetch(0, noop_inst, noop_inst);
    {rob_cap, rs_cap, lsq_cap} = {2'd2, 2'd2, 2'd2};
    end_test("partial dispatch", start);
  endtask

  initial
  begin
    clock   = 1'b0;
    reset   = 1'b1;
    rob_cap = 2'd2;
    rs_cap  = 2'd2;
    lsq_cap = 2'd2;
    drive_fetch(0, noop_inst, noop_inst);
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    reset_test();
    integer_decode_test();
    mem_branch_test();
    halt_illegal_test();
    backpressure_test();
    partial_dispatch_test();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

/* source/decode_dispatch.sv */
`timescale 1ns/100ps
// decode and dispatch stage of a two-wide in-order front end
// fetch offers up to two words per cycle, up to fetch_need are taken; decoded
// entries leave in order as capacity in rob, rs and lsq allows
module decode_dispatch import decode_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [inst_width-1:0]    fetch_inst0,  // older lane
  input  logic [inst_width-1:0]    fetch_inst1,
  input  logic                     fetch_valid0,
  input  logic                     fetch_valid1,
  input  logic [cap_width-1:0]     rob_cap,
  input  logic [cap_width-1:0]     rs_cap,
  input  logic [cap_width-1:0]     lsq_cap,
  output logic [cap_width-1:0]     fetch_need,
  output logic                     disp_valid0, disp_valid1,
  output opa_sel_e                 disp_opa_select0, disp_opa_select1,
  output opb_sel_e                 disp_opb_select0, disp_opb_select1,
  output alu_func_e                disp_alu_func0, disp_alu_func1,
  output logic [reg_idx_width-1:0] disp_ra_idx0, disp_ra_idx1,
  output logic [reg_idx_width-1:0] disp_rb_idx0, disp_rb_idx1,
  output logic [reg_idx_width-1:0] disp_dest_idx0, disp_dest_idx1,
  output logic                     disp_rd_mem0, disp_rd_mem1,
  output logic                     disp_wr_mem0, disp_wr_mem1,
  output logic                     disp_cond_branch0, disp_cond_branch1,
  output logic                     disp_uncond_branch0, disp_uncond_branch1,
  output logic                     disp_halt0, disp_halt1,
  output logic                     disp_illegal0, disp_illegal1
);

  opa_sel_e                 dec_opa_select0, dec_opa_select1;
  opb_sel_e                 dec_opb_select0, dec_opb_select1;
  alu_func_e                dec_alu_func0, dec_alu_func1;
  logic [reg_idx_width-1:0] dec_ra_idx0, dec_ra_idx1, dec_rb_idx0, dec_rb_idx1;
  logic [reg_idx_width-1:0] dec_dest_idx0, dec_dest_idx1;
  logic                     dec_rd_mem0, dec_wr_mem0, dec_cond_branch0, dec_uncond_branch0;
  logic                     dec_rd_mem1, dec_wr_mem1, dec_cond_branch1, dec_uncond_branch1;
  logic                     dec_halt0, dec_illegal0, dec_halt1, dec_illegal1;
  logic [cap_width-1:0]     occupancy;
  logic [cap_width-1:0]     dispatch_count;
  logic                     slot_valid0, slot_valid1;

  inst_decoder decoder0 (
    .inst(fetch_inst0), .inst_valid(fetch_valid0),
    .opa_select(dec_opa_select0), .opb_select(dec_opb_select0), .alu_func(dec_alu_func0),
    .ra_idx(dec_ra_idx0), .rb_idx(dec_rb_idx0), .dest_idx(dec_dest_idx0),
    .rd_mem(dec_rd_mem0), .wr_mem(dec_wr_mem0), .cond_branch(dec_cond_branch0),
    .uncond_branch(dec_uncond_branch0), .halt(dec_halt0), .illegal(dec_illegal0)
  );

  inst_decoder decoder1 (
    .inst(fetch_inst1), .inst_valid(fetch_valid1),
    .opa_select(dec_opa_select1), .opb_select(dec_opb_select1), .alu_func(dec_alu_func1),
    .ra_idx(dec_ra_idx1), .rb_idx(dec_rb_idx1), .dest_idx(dec_dest_idx1),
    .rd_mem(dec_rd_mem1), .wr_mem(dec_wr_mem1), .cond_branch(dec_cond_branch1),
    .uncond_branch(dec_uncond_branch1), .halt(dec_halt1), .illegal(dec_illegal1)
  );

  dispatch_control control (
    .occupancy(occupancy), .rob_cap(rob_cap), .rs_cap(rs_cap), .lsq_cap(lsq_cap),
    .dispatch_count(dispatch_count), .fetch_need(fetch_need)
  );

  dispatch_buffer buffer (
    .clock(clock), .reset(reset),
    .dispatch_count(dispatch_count), .fetch_need(fetch_need),
    .in_valid0(fetch_valid0), .in_valid1(fetch_valid1),
    .in_opa_select0(dec_opa_select0), .in_opa_select1(dec_opa_select1),
    .in_opb_select0(dec_opb_select0), .in_opb_select1(dec_opb_select1),
    .in_alu_func0(dec_alu_func0), .in_alu_func1(dec_alu_func1),
    .in_ra_idx0(dec_ra_idx0), .in_ra_idx1(dec_ra_idx1),
    .in_rb_idx0(dec_rb_idx0), .in_rb_idx1(dec_rb_idx1),
    .in_dest_idx0(dec_dest_idx0), .in_dest_idx1(dec_dest_idx1),
    .in_rd_mem0(dec_rd_mem0), .in_wr_mem0(dec_wr_mem0),
    .in_cond_branch0(dec_cond_branch0), .in_uncond_branch0(dec_uncond_branch0),
    .in_halt0(dec_halt0), .in_illegal0(dec_illegal0),
    .in_rd_mem1(dec_rd_mem1), .in_wr_mem1(dec_wr_mem1),
    .in_cond_branch1(dec_cond_branch1), .in_uncond_branch1(dec_uncond_branch1),
    .in_halt1(dec_halt1), .in_illegal1(dec_illegal1),
    .occupancy(occupancy), .slot_valid0(slot_valid0), .slot_valid1(slot_valid1),
    .slot_opa_select0(disp_opa_select0), .slot_opa_select1(disp_opa_select1),
    .slot_opb_select0(disp_opb_select0), .slot_opb_select1(disp_opb_select1),
    .slot_alu_func0(disp_alu_func0), .slot_alu_func1(disp_alu_func1),
    .slot_ra_idx0(disp_ra_idx0), .slot_ra_idx1(disp_ra_idx1),
    .slot_rb_idx0(disp_rb_idx0), .slot_rb_idx1(disp_rb_idx1),
    .slot_dest_idx0(disp_dest_idx0), .slot_dest_idx1(disp_dest_idx1),
    .slot_rd_mem0(disp_rd_mem0), .slot_wr_mem0(disp_wr_mem0),
    .slot_cond_branch0(disp_cond_branch0), .slot_uncond_branch0(disp_uncond_branch0),
    .slot_halt0(disp_halt0), .slot_illegal0(disp_illegal0),
    .slot_rd_mem1(disp_rd_mem1), .slot_wr_mem1(disp_wr_mem1),
    .slot_cond_branch1(disp_cond_branch1), .slot_uncond_branch1(disp_uncond_branch1),
    .slot_halt1(disp_halt1), .slot_illegal1(disp_illegal1)
  );

  // a lane goes out only if the count reaches it
  assign disp_valid0 = slot_valid0 && (dispatch_count != '0);
  assign disp_valid1 = slot_valid1 && (dispatch_count == cap_width'(2));

endmodule

/* source/dispatch_buffer.sv */
`timescale 1ns/100ps
// two-entry in-order buffer of decoded instructions, slot 0 oldest
// each edge drops dispatched entries, shifts survivors forward and appends
// the fetch lanes accepted under fetch_need
module dispatch_buffer import decode_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic [cap_width-1:0]     dispatch_count, // leaving from the front
  input  logic [cap_width-1:0]     fetch_need,     // lanes fetch may hand over
  input  logic                     in_valid0,
  input  logic                     in_valid1,
  input  opa_sel_e                 in_opa_select0, in_opa_select1,
  input  opb_sel_e                 in_opb_select0, in_opb_select1,
  input  alu_func_e                in_alu_func0, in_alu_func1,
  input  logic [reg_idx_width-1:0] in_ra_idx0, in_ra_idx1,
  input  logic [reg_idx_width-1:0] in_rb_idx0, in_rb_idx1,
  input  logic [reg_idx_width-1:0] in_dest_idx0, in_dest_idx1,
  input  logic                     in_rd_mem0, in_wr_mem0, in_cond_branch0,
  input  logic                     in_uncond_branch0, in_halt0, in_illegal0,
  input  logic                     in_rd_mem1, in_wr_mem1, in_cond_branch1,
  input  logic                     in_uncond_branch1, in_halt1, in_illegal1,
  output logic [cap_width-1:0]     occupancy,
  output logic                     slot_valid0,
  output logic                     slot_valid1,
  output opa_sel_e                 slot_opa_select0, slot_opa_select1,
  output opb_sel_e                 slot_opb_select0, slot_opb_select1,
  output alu_func_e                slot_alu_func0, slot_alu_func1,
  output logic [reg_idx_width-1:0] slot_ra_idx0, slot_ra_idx1,
  output logic [reg_idx_width-1:0] slot_rb_idx0, slot_rb_idx1,
  output logic [reg_idx_width-1:0] slot_dest_idx0, slot_dest_idx1,
  output logic                     slot_rd_mem0, slot_wr_mem0, slot_cond_branch0,
  output logic                     slot_uncond_branch0, slot_halt0, slot_illegal0,
  output logic                     slot_rd_mem1, slot_wr_mem1, slot_cond_branch1,
  output logic                     slot_uncond_branch1, slot_halt1, slot_illegal1
);

  typedef struct packed {
    opa_sel_e                 opa_select;
    opb_sel_e                 opb_select;
    alu_func_e                alu_func;
    logic [reg_idx_width-1:0] ra_idx;
    logic [reg_idx_width-1:0] rb_idx;
    logic [reg_idx_width-1:0] dest_idx;
    logic                     rd_mem;
    logic                     wr_mem;
    logic                     cond_branch;
    logic                     uncond_branch;
    logic                     halt;
    logic                     illegal;
  } entry_t;

  // decoded form of noop_inst
  localparam entry_t noop_entry = '{opa_is_rega, opb_is_regb, alu_bis, noop_inst[25:21],
                                    noop_inst[20:16], noop_inst[4:0], 1'b0, 1'b0, 1'b0,
                                    1'b0, 1'b0, 1'b0};

  entry_t               slot_q [2];
  entry_t               next_q [2];
  entry_t               in_entry [2];
  logic [1:0]           valid_q;
  logic [1:0]           next_valid;
  logic [1:0]           accept;
  logic [cap_width-1:0] keep; // survivors after dispatch

  assign in_entry[0] = '{in_opa_select0, in_opb_select0, in_alu_func0, in_ra_idx0,
                         in_rb_idx0, in_dest_idx0, in_rd_mem0, in_wr_mem0, in_cond_branch0,
                         in_uncond_branch0, in_halt0, in_illegal0};
  assign in_entry[1] = '{in_opa_select1, in_opb_select1, in_alu_func1, in_ra_idx1,
                         in_rb_idx1, in_dest_idx1, in_rd_mem1, in_wr_mem1, in_cond_branch1,
                         in_uncond_branch1, in_halt1, in_illegal1};

  assign occupancy = cap_width'(valid_q[0]) + cap_width'(valid_q[1]);
  assign keep      = occupancy - dispatch_count;
  assign accept[0] = in_valid0 && (fetch_need != '0);
  assign accept[1] = in_valid1 && (fetch_need == cap_width'(2));

  always_comb
  begin
    next_q     = in_entry; // empty after dispatch, take both lanes
    next_valid = accept;
    case (keep)
      cap_width'(2):
      begin
        next_q     = slot_q; // nothing left, nothing taken
        next_valid = 2'b11;
      end
      cap_width'(1):
      begin
        next_q[0]  = dispatch_count[0] ? slot_q[1] : slot_q[0];
        next_q[1]  = in_entry[0];
        next_valid = {accept[0], 1'b1};
      end
      default:
      begin
      end
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      valid_q   <= '0;
      slot_q[0] <= noop_entry;
      slot_q[1] <= noop_entry;
    end
    else
    begin
      valid_q <= next_valid;
      slot_q  <= next_q;
    end
  end

  assign slot_valid0         = valid_q[0];
  assign slot_opa_select0    = slot_q[0].opa_select;
  assign slot_opb_select0    = slot_q[0].opb_select;
  assign slot_alu_func0      = slot_q[0].alu_func;
  assign slot_ra_idx0        = slot_q[0].ra_idx;
  assign slot_rb_idx0        = slot_q[0].rb_idx;
  assign slot_dest_idx0      = slot_q[0].dest_idx;
  assign slot_rd_mem0        = slot_q[0].rd_mem;
  assign slot_wr_mem0        = slot_q[0].wr_mem;
  assign slot_cond_branch0   = slot_q[0].cond_branch;
  assign slot_uncond_branch0 = slot_q[0].uncond_branch;
  assign slot_halt0          = slot_q[0].halt;
  assign slot_illegal0       = slot_q[0].illegal;
  assign slot_valid1         = valid_q[1];
  assign slot_opa_select1    = slot_q[1].opa_select;
  assign slot_opb_select1    = slot_q[1].opb_select;
  assign slot_alu_func1      = slot_q[1].alu_func;
  assign slot_ra_idx1        = slot_q[1].ra_idx;
  assign slot_rb_idx1        = slot_q[1].rb_idx;
  assign slot_dest_idx1      = slot_q[1].dest_idx;
  assign slot_rd_mem1        = slot_q[1].rd_mem;
  assign slot_wr_mem1        = slot_q[1].wr_mem;
  assign slot_cond_branch1   = slot_q[1].cond_branch;
  assign slot_uncond_branch1 = slot_q[1].uncond_branch;
  assign slot_halt1          = slot_q[1].halt;
  assign slot_illegal1       = slot_q[1].illegal;

  // fetch fills lanes in order
  lane1_needs_lane0: assert property (@(posedge clock) disable iff (reset)
    in_valid1 |-> in_valid0);

  // fetch_need from the control block must never overfill the two slots
  no_overfill: assert property (@(posedge clock) disable iff (reset)
    (keep + accept[0] + accept[1]) <= 2);

endmodule

/* source/dispatch_control.sv */
`timescale 1ns/100ps
// dispatch count and fetch request from buffer occupancy and the three
// downstream capacities; purely combinational
module dispatch_control import decode_pkg::*; (
  input  logic [cap_width-1:0] occupancy,
  input  logic [cap_width-1:0] rob_cap,
  input  logic [cap_width-1:0] rs_cap,
  input  logic [cap_width-1:0] lsq_cap,
  output logic [cap_width-1:0] dispatch_count,
  output logic [cap_width-1:0] fetch_need
);

  logic [cap_width-1:0] min_cap;

  always_comb
  begin
    min_cap = rob_cap; // tightest downstream limit
    if (rs_cap < min_cap)
      min_cap = rs_cap;
    if (lsq_cap < min_cap)
      min_cap = lsq_cap;
  end

  assign dispatch_count = (occupancy < min_cap) ? occupancy : min_cap;
  assign fetch_need     = cap_width'(2) - occupancy + dispatch_count; // free after shift

  // capacities above the issue width would overrun the buffer math
  cap_in_range: assert final (rob_cap <= 2 && rs_cap <= 2 && lsq_cap <= 2)
    else $error("capacity above 2: rob %0d rs %0d lsq %0d", rob_cap, rs_cap, lsq_cap);

endmodule

/* source/inst_decoder.sv */
`timescale 1ns/100ps
// combinational decode of one instruction lane
// an invalid lane or an illegal word comes out as noop fields
module inst_decoder import decode_pkg::*; (
  input  logic [inst_width-1:0]    inst,
  input  logic                     inst_valid,
  output opa_sel_e                 opa_select,
  output opb_sel_e                 opb_select,
  output alu_func_e                alu_func,
  output logic [reg_idx_width-1:0] ra_idx,
  output logic [reg_idx_width-1:0] rb_idx,
  output logic [reg_idx_width-1:0] dest_idx,
  output logic                     rd_mem,
  output logic                     wr_mem,
  output logic                     cond_branch,
  output logic                     uncond_branch,
  output logic                     halt,
  output logic                     illegal
);

  typedef enum logic [1:0] {dest_none, dest_ra, dest_rc} dest_sel_e;

  dest_sel_e dest_select;
  func_e     func;

  assign func   = inst[11:5];
  assign ra_idx = inst[25:21];
  assign rb_idx = inst[20:16];

  always_comb
  begin
    opa_select    = opa_is_rega; // noop defaults
    opb_select    = opb_is_regb;
    alu_func      = alu_addq;
    dest_select   = dest_none;
    rd_mem        = 1'b0;
    wr_mem        = 1'b0;
    cond_branch   = 1'b0;
    uncond_branch = 1'b0;
    halt          = 1'b0;
    illegal       = 1'b0;
    if (inst_valid)
    begin
      case (inst[31:26]) inside
        op_pal:
        begin
          if (inst[25:0] == '0)
            halt = 1'b1; // call_pal 0
          else
            illegal = 1'b1;
        end
        op_inta, op_intl, op_ints, op_intm:
        begin
          opb_select  = inst[12] ? opb_is_alu_imm : opb_is_regb; // literal form
          dest_select = dest_rc;
          case (inst[31:26])
            op_inta:
              case (func)
                fn_addq:   alu_func = alu_addq;
                fn_subq:   alu_func = alu_subq;
                fn_cmpult: alu_func = alu_cmpult;
                fn_cmpeq:  alu_func = alu_cmpeq;
                fn_cmpule: alu_func = alu_cmpule;
                fn_cmplt:  alu_func = alu_cmplt;
                fn_cmple:  alu_func = alu_cmple;
                default:   illegal = 1'b1;
              endcase
            op_intl:
              case (func)
                fn_and:   alu_func = alu_and;
                fn_bic:   alu_func = alu_bic;
                fn_bis:   alu_func = alu_bis;
                fn_ornot: alu_func = alu_ornot;
                fn_xor:   alu_func = alu_xor;
                fn_eqv:   alu_func = alu_eqv;
                default:  illegal = 1'b1;
              endcase
            op_ints:
              case (func)
                fn_srl:  alu_func = alu_srl;
                fn_sll:  alu_func = alu_sll;
                fn_sra:  alu_func = alu_sra;
                default: illegal = 1'b1;
              endcase
            default:
              if (func == fn_mulq)
                alu_func = alu_mulq;
              else
                illegal = 1'b1;
          endcase
        end
        op_jsr:
        begin
          opa_select    = opa_is_not3; // jmp, jsr, ret share one form
          alu_func      = alu_and;     // target = rb & ~3
          dest_select   = dest_ra;
          uncond_branch = 1'b1;
        end
        op_lda, op_ldq:
        begin
          opa_select  = opa_is_mem_disp;
          dest_select = dest_ra;
          rd_mem      = (inst[31:26] == op_ldq);
        end
        op_stq:
        begin
          wr_mem = 1'b1; // address from rb + disp, data from ra
        end
        op_br, op_bsr:
        begin
          opa_select    = opa_is_npc;
          opb_select    = opb_is_br_disp;
          dest_select   = dest_ra; // return address
          uncond_branch = 1'b1;
        end
        [6'h38:6'h3f]:
        begin
          opb_select  = opb_is_br_disp;
          cond_branch = 1'b1; // ra tested by the branch unit
        end
        default:
          illegal = 1'b1; // fp branches, unlisted groups
      endcase
      if (illegal)
      begin
        opa_select  = opa_is_rega; // drop partial fields
        opb_select  = opb_is_regb;
        alu_func    = alu_addq;
        dest_select = dest_none;
      end
    end
  end

  // destination index mux
  always_comb
  begin
    case (dest_select)
      dest_rc: dest_idx = inst[4:0];
      dest_ra: dest_idx = inst[25:21];
      default: dest_idx = zero_reg;
    endcase
  end

  // downstream units key off a single class flag per instruction
  flag_class_onehot: assert final (
    $onehot0({halt, illegal, rd_mem, wr_mem, cond_branch, uncond_branch}))
    else $error("decoder raised more than one class flag for %h", inst);

endmodule

/* source/decode_pkg.sv */
// shared widths, register constants and encodings for the two-wide decode and
// dispatch stage; every RTL module and the testbench import this package
package decode_pkg;

  localparam int inst_width    = 32;
  localparam int word_width    = 64; // datapath width fed by the opa/opb selects
  localparam int reg_idx_width = 5;
  localparam int cap_width     = 2;  // counts and capacities, 0 to 2

  localparam logic [reg_idx_width-1:0] zero_reg = 5'd31; // r31, no writeback
  localparam logic [inst_width-1:0] noop_inst = 32'h47ff_041f; // bis r31,r31,r31

  // major opcodes, bits 31..26
  typedef enum logic [5:0] {
    op_pal  = 6'h00,
    op_lda  = 6'h08,
    op_inta = 6'h10,
    op_intl = 6'h11,
    op_ints = 6'h12,
    op_intm = 6'h13,
    op_jsr  = 6'h1a,
    op_ldq  = 6'h29,
    op_stq  = 6'h2d,
    op_br   = 6'h30,
    op_bsr  = 6'h34
  } opcode_e; // 0x38..0x3f are integer conditional branches

  // function codes, bits 11..5; values repeat across groups so the major
  // opcode picks the meaning
  typedef logic [6:0] func_e;
  localparam func_e fn_addq   = 7'h20;
  localparam func_e fn_subq   = 7'h29;
  localparam func_e fn_cmpult = 7'h1d;
  localparam func_e fn_cmpeq  = 7'h2d;
  localparam func_e fn_cmpule = 7'h3d;
  localparam func_e fn_cmplt  = 7'h4d;
  localparam func_e fn_cmple  = 7'h6d;
  localparam func_e fn_and    = 7'h00;
  localparam func_e fn_bic    = 7'h08;
  localparam func_e fn_bis    = 7'h20;
  localparam func_e fn_ornot  = 7'h28;
  localparam func_e fn_xor    = 7'h40;
  localparam func_e fn_eqv    = 7'h48;
  localparam func_e fn_srl    = 7'h34;
  localparam func_e fn_sll    = 7'h39;
  localparam func_e fn_sra    = 7'h3c;
  localparam func_e fn_mulq   = 7'h20;

  typedef enum logic [4:0] {
    alu_addq, alu_subq, alu_and, alu_bic, alu_bis, alu_ornot,
    alu_xor, alu_eqv, alu_srl, alu_sll, alu_sra, alu_mulq,
    alu_cmpeq, alu_cmplt, alu_cmple, alu_cmpult, alu_cmpule
  } alu_func_e;

  // operand a source, each a word_width value
  typedef enum logic [1:0] {
    opa_is_rega,
    opa_is_npc,
    opa_is_not3,     // ~3, word-aligns a jump target
    opa_is_mem_disp  // sign-extended 16-bit displacement
  } opa_sel_e;

  // operand b source
  typedef enum logic [1:0] {
    opb_is_regb,
    opb_is_alu_imm,  // zero-extended 8-bit literal
    opb_is_br_disp   // 21-bit branch displacement, scaled by 4
  } opb_sel_e;

endpackage
